// File: mfifo_settings.svh
/* Build-time sizes for the shared multi-FIFO
   The depth should be a power of two and the FIFO count at least two */

`ifndef MFIFO_SETTINGS_SVH
`define MFIFO_SETTINGS_SVH

// Number of logical FIFOs sharing the storage
`define MFIFO_NUM_FIFOS 2

// Total entries in the shared data RAM and in the pointer RAM
`define MFIFO_DEPTH 8

// Bits in one data word
`define MFIFO_WIDTH 8

`endif

// File: mfifoPkg.sv
/* Types shared by all blocks of the multi-FIFO, sized from the settings header */

`default_nettype none

`include "mfifo_settings.svh"

package mfifoPkg;

  // A single FIFO still gets a one bit id so the port never has zero width
  localparam int FifoIdWidth = (`MFIFO_NUM_FIFOS > 1) ? $clog2(`MFIFO_NUM_FIFOS) : 1;
  localparam int AddrWidth   = $clog2(`MFIFO_DEPTH);
  // Counts run from zero up to the full depth inclusive
  localparam int CountWidth  = $clog2(`MFIFO_DEPTH + 1);

  typedef logic [FifoIdWidth-1:0]  fifoIdT;
  typedef logic [AddrWidth-1:0]    addrT;
  typedef logic [`MFIFO_WIDTH-1:0] dataT;
  typedef logic [CountWidth-1:0]   countT;

endpackage

`default_nettype wire

// File: flopRam.sv
/* Flop array with one write port and a zero-latency read port
   Contents are not reset, so reads of unwritten entries return X */

`timescale 1ns/10ps
`default_nettype none

`include "mfifo_settings.svh"

module flopRam #(
  parameter type payloadT = mfifoPkg::dataT
) (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           wrValid,
  input  wire mfifoPkg::addrT wrAddr,
  input  wire payloadT        wrData,
  input  wire mfifoPkg::addrT rdAddr,
  output payloadT             rdData
);

  // One word per shared storage entry
  payloadT mem [`MFIFO_DEPTH];

  // Write lands at the clock edge
  always_ff @(posedge clk) begin
    if (wrValid) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Read is purely combinational so a write is seen only after its edge
  assign rdData = mem[rdAddr];

  // An unknown write address would corrupt an entry owned by another FIFO
  wrAddrKnown: assert property (@(posedge clk) disable iff (rst)
    wrValid |-> !$isunknown(wrAddr));

endmodule

`default_nettype wire

// File: pushCreditReceiver.sv
/* Returns push credits to the sender, at most one per cycle
   The sender must start with zero credits and may push only with one in hand */

`timescale 1ns/10ps
`default_nettype none

`include "mfifo_settings.svh"

module pushCreditReceiver (
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic pushValid,
  input  wire logic pushCreditStall,
  input  wire logic refillValid,
  output logic      pushCredit
);

  // Credits the receiver still has to hand back
  mfifoPkg::countT owed;
  // Model of the credits the sender currently holds
  mfifoPkg::countT senderCredit;
  logic            sendNow;

  // A pulse goes out whenever something is owed and the sender is not stalling
  assign sendNow = !pushCreditStall && (owed != '0);

  // Every free storage entry starts out as an owed credit
  always_ff @(posedge clk) begin
    if (rst) begin
      owed       <= mfifoPkg::countT'(`MFIFO_DEPTH);
      pushCredit <= 1'b0;
    end else begin
      // A refill frees an entry and a pulse hands one back
      owed       <= owed + mfifoPkg::countT'(refillValid) - mfifoPkg::countT'(sendNow);
      pushCredit <= sendNow;
    end
  end

  // Sender side bookkeeping, only used for checking
  always_ff @(posedge clk) begin
    if (rst) begin
      senderCredit <= '0;
    end else begin
      senderCredit <= senderCredit + mfifoPkg::countT'(pushCredit)
                      - mfifoPkg::countT'(pushValid);
    end
  end

  // A credit arriving in the same cycle may be spent right away
  pushWithinCredit: assert property (@(posedge clk) disable iff (rst)
    pushValid |-> (senderCredit != '0) || pushCredit);

  // Credits in flight can never exceed the storage depth
  creditBounded: assert property (@(posedge clk) disable iff (rst)
    (owed + senderCredit) <= mfifoPkg::countT'(`MFIFO_DEPTH));

endmodule

`default_nettype wire

// File: freeList.sv
/* Tracks which shared entries are free, offering the lowest one
   Allocation relies on the credit protocol and is never refused */

`timescale 1ns/10ps
`default_nettype none

`include "mfifo_settings.svh"

module freeList (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire logic           pushValid,
  input  wire logic           refillValid,
  input  wire mfifoPkg::addrT refillAddr,
  output mfifoPkg::addrT      allocAddr,
  output logic                pushFull
);

  // One bit per storage entry, set while the entry is free
  logic [`MFIFO_DEPTH-1:0] freeMask;

  // Priority encoder, the lowest set bit wins
  always_comb begin
    allocAddr = '0;
    for (int i = `MFIFO_DEPTH - 1; i >= 0; i--) begin
      if (freeMask[i]) begin
        allocAddr = mfifoPkg::addrT'(i);
      end
    end
  end

  assign pushFull = (freeMask == '0);

  // The released entry is in use, so it never equals allocAddr in the same cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      freeMask <= '1;
    end else begin
      if (refillValid) begin
        freeMask[refillAddr] <= 1'b1;
      end
      if (pushValid) begin
        freeMask[allocAddr] <= 1'b0;
      end
    end
  end

  // A push with nothing free means the sender overran its credits
  noAllocWhenFull: assert property (@(posedge clk) disable iff (rst)
    pushValid |-> !pushFull);

  // Releasing a free entry means a linked list went out of step with storage
  noDoubleFree: assert property (@(posedge clk) disable iff (rst)
    refillValid |-> !freeMask[refillAddr]);

endmodule

`default_nettype wire

// File: linkedListCtrl.sv
/* Keeps one linked list per logical FIFO over the shared storage
   Both RAMs must read with zero latency for the head update to be correct */

`timescale 1ns/10ps
`default_nettype none

`include "mfifo_settings.svh"

module linkedListCtrl (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         pushValid,
  input  wire mfifoPkg::fifoIdT             pushFifoId,
  input  wire mfifoPkg::addrT               allocAddr,
  input  wire logic [`MFIFO_NUM_FIFOS-1:0]  stageFree,
  input  wire mfifoPkg::addrT               nextPtr,
  output logic                              ptrWrValid,
  output mfifoPkg::addrT                    ptrWrAddr,
  output mfifoPkg::addrT                    ptrWrData,
  output logic                              refillValid,
  output mfifoPkg::fifoIdT                  refillFifoId,
  output mfifoPkg::addrT                    refillAddr,
  output logic [`MFIFO_NUM_FIFOS-1:0]       popEmpty
);

  mfifoPkg::addrT   head [`MFIFO_NUM_FIFOS];
  mfifoPkg::addrT   tail [`MFIFO_NUM_FIFOS];
  mfifoPkg::countT  count [`MFIFO_NUM_FIFOS];
  // Mirror of the staging valid bits, rebuilt from refills and stageFree
  logic [`MFIFO_NUM_FIFOS-1:0] stageHeld;
  logic [`MFIFO_NUM_FIFOS-1:0] eligible;
  // FIFO that gets first chance at the next refill
  mfifoPkg::fifoIdT rrPtr;

  // Appending to a non-empty list links the old tail to the new entry
  assign ptrWrValid = pushValid && (count[pushFifoId] != '0);
  assign ptrWrAddr  = tail[pushFifoId];
  assign ptrWrData  = allocAddr;

  // A FIFO may refill when it has entries and its staging slot opens
  always_comb begin
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      eligible[i] = (count[i] != '0) && stageFree[i];
      popEmpty[i] = (count[i] == '0) && !stageHeld[i];
    end
  end

  // Round-robin search starting at rrPtr
  always_comb begin
    int idx;
    refillValid  = 1'b0;
    refillFifoId = '0;
    for (int k = 0; k < `MFIFO_NUM_FIFOS; k++) begin
      idx = (int'(rrPtr) + k) % `MFIFO_NUM_FIFOS;
      if (!refillValid && eligible[idx]) begin
        refillValid  = 1'b1;
        refillFifoId = mfifoPkg::fifoIdT'(idx);
      end
    end
  end

  // The head is what both RAMs read this cycle
  assign refillAddr = head[refillFifoId];

  always_ff @(posedge clk) begin
    if (rst) begin
      rrPtr <= '0;
    end else if (refillValid) begin
      // Skip past the winner so the others go first next time
      rrPtr <= mfifoPkg::fifoIdT'((int'(refillFifoId) + 1) % `MFIFO_NUM_FIFOS);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
        head[i]  <= '0;
        tail[i]  <= '0;
        count[i] <= '0;
      end
      stageHeld <= '0;
    end else begin
      for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
        logic inc;
        logic dec;
        inc = pushValid && (pushFifoId == mfifoPkg::fifoIdT'(i));
        dec = refillValid && (refillFifoId == mfifoPkg::fifoIdT'(i));
        // Push and refill together leave the count alone
        if (inc && !dec) begin
          count[i] <= count[i] + 1'b1;
        end else if (dec && !inc) begin
          count[i] <= count[i] - 1'b1;
        end
        if (inc) begin
          tail[i] <= allocAddr;
        end
        // The last entry leaving while a new one arrives has no valid link yet
        if (dec) begin
          head[i] <= (inc && count[i] == mfifoPkg::countT'(1)) ? allocAddr : nextPtr;
        end else if (inc && count[i] == '0) begin
          head[i] <= allocAddr;
        end
        stageHeld[i] <= dec || (stageHeld[i] && !stageFree[i]);
      end
    end
  end

endmodule

`default_nettype wire

// File: popStaging.sv
/* One output register per logical FIFO feeding its valid/ready pop port
   A refill is only accepted into a slot that is empty or popping this cycle */

`timescale 1ns/10ps
`default_nettype none

`include "mfifo_settings.svh"

module popStaging (
  input  wire logic                            clk,
  input  wire logic                            rst,
  input  wire logic                            refillValid,
  input  wire mfifoPkg::fifoIdT                refillFifoId,
  input  wire mfifoPkg::dataT                  refillData,
  input  wire logic [`MFIFO_NUM_FIFOS-1:0]     popReady,
  output logic [`MFIFO_NUM_FIFOS-1:0]          popValid,
  output mfifoPkg::dataT [`MFIFO_NUM_FIFOS-1:0] popData,
  output logic [`MFIFO_NUM_FIFOS-1:0]          stageFree
);

  // Slot can take a word at this edge if it is empty or draining now
  always_comb begin
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      stageFree[i] = !popValid[i] || popReady[i];
    end
  end

  // Valid bits
  always_ff @(posedge clk) begin
    if (rst) begin
      popValid <= '0;
    end else begin
      for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
        // A refill wins over a pop in the same cycle
        if (refillValid && refillFifoId == mfifoPkg::fifoIdT'(i)) begin
          popValid[i] <= 1'b1;
        end else if (popReady[i]) begin
          popValid[i] <= 1'b0;
        end
      end
    end
  end

  // Data registers hold while popReady is low
  always_ff @(posedge clk) begin
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      if (refillValid && refillFifoId == mfifoPkg::fifoIdT'(i)) begin
        popData[i] <= refillData;
      end
    end
  end

  // Overwriting a held word would drop it and leak its credit
  noRefillOverwrite: assert property (@(posedge clk) disable iff (rst)
    refillValid |-> (!popValid[refillFifoId] || popReady[refillFifoId]));

endmodule

`default_nettype wire

// File: sharedMultiFifo.sv
/* Shared-storage multi-FIFO with a valid/credit push and valid/ready pops
   The sender must start from zero credits after reset */

`timescale 1ns/10ps
`default_nettype none

`include "mfifo_settings.svh"

module sharedMultiFifo (
  input  wire logic                             clk,
  input  wire logic                             rst,
  input  wire logic                             pushCreditStall,
  output logic                                  pushCredit,
  input  wire logic                             pushValid,
  input  wire mfifoPkg::dataT                   pushData,
  input  wire mfifoPkg::fifoIdT                 pushFifoId,
  output logic                                  pushFull,
  output logic [`MFIFO_NUM_FIFOS-1:0]           popValid,
  input  wire logic [`MFIFO_NUM_FIFOS-1:0]      popReady,
  output mfifoPkg::dataT [`MFIFO_NUM_FIFOS-1:0] popData,
  output logic [`MFIFO_NUM_FIFOS-1:0]           popEmpty
);

  mfifoPkg::addrT   allocAddr;
  logic             refillValid;
  mfifoPkg::fifoIdT refillFifoId;
  mfifoPkg::addrT   refillAddr;
  mfifoPkg::dataT   refillData;
  mfifoPkg::addrT   nextPtr;
  logic             ptrWrValid;
  mfifoPkg::addrT   ptrWrAddr;
  mfifoPkg::addrT   ptrWrData;
  logic [`MFIFO_NUM_FIFOS-1:0] stageFree;

  pushCreditReceiver creditRx (
    .clk, .rst, .pushValid, .pushCreditStall, .refillValid, .pushCredit
  );

  freeList freeEntries (
    .clk, .rst, .pushValid, .refillValid, .refillAddr, .allocAddr, .pushFull
  );

  // Push data goes straight into the entry the free list offers
  flopRam #(.payloadT(mfifoPkg::dataT)) dataRam (
    .clk, .rst, .wrValid(pushValid), .wrAddr(allocAddr), .wrData(pushData),
    .rdAddr(refillAddr), .rdData(refillData)
  );

  // Link storage, read at the same head address as the data RAM
  flopRam #(.payloadT(mfifoPkg::addrT)) ptrRam (
    .clk, .rst, .wrValid(ptrWrValid), .wrAddr(ptrWrAddr), .wrData(ptrWrData),
    .rdAddr(refillAddr), .rdData(nextPtr)
  );

  linkedListCtrl listCtrl (
    .clk, .rst, .pushValid, .pushFifoId, .allocAddr, .stageFree, .nextPtr,
    .ptrWrValid, .ptrWrAddr, .ptrWrData, .refillValid, .refillFifoId,
    .refillAddr, .popEmpty
  );

  popStaging staging (
    .clk, .rst, .refillValid, .refillFifoId, .refillData, .popReady,
    .popValid, .popData, .stageFree
  );

endmodule

`default_nettype wire

// File: tb_sharedMultiFifo.sv
/* Directed testbench for the shared multi-FIFO, checked against one reference queue per FIFO
   The reference model covers exactly two FIFOs, which matches the default FIFO count */

`timescale 1ns/10ps
`default_nettype none

`include "mfifo_settings.svh"

module tb_sharedMultiFifo;

  // Upper bound on the cycles of one short test and of the random phase
  localparam int ShortCycles  = 80;
  localparam int RandomCycles = 200;
  // Four short tests, the random phase and its drain
  localparam int TotalCycles  = 5 * ShortCycles + RandomCycles;

  logic                                  clk;
  logic                                  rst;
  logic                                  pushCreditStall;
  logic                                  pushCredit;
  logic                                  pushValid;
  mfifoPkg::dataT                        pushData;
  mfifoPkg::fifoIdT                      pushFifoId;
  logic                                  pushFull;
  logic [`MFIFO_NUM_FIFOS-1:0]           popValid;
  logic [`MFIFO_NUM_FIFOS-1:0]           popReady;
  mfifoPkg::dataT [`MFIFO_NUM_FIFOS-1:0] popData;
  logic [`MFIFO_NUM_FIFOS-1:0]           popEmpty;

  // Credits the testbench holds as the sender
  int             credits;
  int             valueErrors;
  int             otherErrors;
  logic [15:0]    lfsrState;
  string          testName;
  mfifoPkg::dataT refQ0 [$];
  mfifoPkg::dataT refQ1 [$];

  sharedMultiFifo dut (.*);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Ends a run that hangs, allowing twice the budget of all tests
  initial begin
    #(2 * TotalCycles * 40);
    $display("Watchdog expired, the tests did not finish in time");
    $display("test failed");
    $finish;
  end

  task automatic checkValue(input string what, input int expected, input int actual);
    assert (expected == actual) else begin
      $display("FAILED %s %s: expected %0h, actual %0h", testName, what, expected, actual);
      valueErrors++;
    end
  endtask

  task automatic checkTrue(input bit cond, input string what);
    assert (cond) else begin
      $display("Error in %s: %s", testName, what);
      otherErrors++;
    end
  endtask

  // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic takeBits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[6:0], lfsrState[0]};
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  // Every word leaving the DUT must be the oldest one pushed into its FIFO
  task automatic checkPops();
    mfifoPkg::dataT expected;
    for (int i = 0; i < `MFIFO_NUM_FIFOS; i++) begin
      if (popValid[i] && popReady[i]) begin
        if (((i == 0) ? refQ0.size() : refQ1.size()) == 0) begin
          checkTrue(1'b0, $sformatf("FIFO %0d popped a word that was never pushed", i));
        end else begin
          expected = (i == 0) ? refQ0.pop_front() : refQ1.pop_front();
          checkValue($sformatf("pop data FIFO %0d", i), expected, popData[i]);
        end
      end
    end
  endtask

  // Samples at the falling edge, then returns just after the next rising edge
  task automatic advance();
    @(negedge clk);
    checkPops();
    if (pushValid) begin
      if (pushFifoId == '0) begin
        refQ0.push_back(pushData);
      end else begin
        refQ1.push_back(pushData);
      end
    end
    @(posedge clk);
    #2;
    pushValid = 1'b0;
    if (pushCredit) begin
      credits++;
    end
  endtask

  // A push only goes out with a credit in hand
  task automatic tryPush(input mfifoPkg::fifoIdT id, input mfifoPkg::dataT data,
                         output bit pushed);
    pushed = (credits > 0);
    if (pushed) begin
      credits--;
      pushValid  = 1'b1;
      pushFifoId = id;
      pushData   = data;
    end
  endtask

  // Pops everything still queued and waits until all credits are back
  task automatic drainAll();
    int n;
    popReady = '1;
    n = 0;
    while ((refQ0.size() + refQ1.size() > 0 || credits != `MFIFO_DEPTH) && n < ShortCycles) begin
      advance();
      n++;
    end
    checkTrue(n < ShortCycles, "drain did not finish in time");
    checkValue("credits after drain", `MFIFO_DEPTH, credits);
    checkValue("popEmpty after drain", (1 << `MFIFO_NUM_FIFOS) - 1, popEmpty);
    checkValue("pushFull after drain", 0, pushFull);
  endtask

  task automatic creditInit();
    testName = "creditInit";
    checkValue("pushCredit after reset", 0, pushCredit);
    checkValue("popValid after reset", 0, popValid);
    checkValue("popEmpty after reset", (1 << `MFIFO_NUM_FIFOS) - 1, popEmpty);
    repeat (5) advance();
    checkValue("credits while stalled", 0, credits);
    pushCreditStall = 1'b0;
    // One cycle for the first pulse, then the full depth and 20 quiet cycles
    repeat (`MFIFO_DEPTH + 21) advance();
    checkValue("credits after release", `MFIFO_DEPTH, credits);
  endtask

  task automatic singleFifoOrder();
    bit pushed;
    testName = "singleFifoOrder";
    popReady = '1;
    for (int i = 0; i < 5; i++) begin
      tryPush(1'b0, mfifoPkg::dataT'(8'hA0 + i), pushed);
      checkTrue(pushed, "no credit for a push");
      checkValue("popEmpty FIFO 1", 1, popEmpty[1]);
      advance();
    end
    for (int n = 0; n < ShortCycles && refQ0.size() > 0; n++) begin
      checkValue("popEmpty FIFO 1", 1, popEmpty[1]);
      advance();
    end
    drainAll();
  endtask

  task automatic fillShared();
    bit pushed;
    int count;
    int n;
    testName = "fillShared";
    popReady = '0;
    count = 0;
    n = 0;
    // The staging register holds one word outside the RAM, so filling takes depth plus one
    while (count < `MFIFO_DEPTH + 1 && n < ShortCycles) begin
      tryPush(1'b1, mfifoPkg::dataT'(8'h50 + count), pushed);
      if (pushed) begin
        count++;
      end
      advance();
      n++;
    end
    checkTrue(count == `MFIFO_DEPTH + 1, "credits ran out before the storage filled");
    checkValue("pushFull", 1, pushFull);
    checkValue("credits with storage full", 0, credits);
    // Only FIFO 0 is empty while FIFO 1 holds every word
    checkValue("popEmpty with storage full", 1, popEmpty);
    checkValue("staged word FIFO 1", refQ1[0], popData[1]);
    drainAll();
  endtask

  task automatic backPressure();
    bit pushed;
    int n;
    testName = "backPressure";
    popReady = 2'b10;
    tryPush(1'b0, 8'hC3, pushed);
    advance();
    n = 0;
    while (!popValid[0] && n < ShortCycles) begin
      advance();
      n++;
    end
    checkTrue(popValid[0], "FIFO 0 never presented its word");
    // FIFO 0 keeps growing behind its held word while FIFO 1 flows
    for (int i = 0; i < 16; i++) begin
      if (i < 12) begin
        tryPush((i % 3 == 0) ? 1'b0 : 1'b1, mfifoPkg::dataT'(8'h20 + i), pushed);
      end
      checkValue("popValid FIFO 0 held", 1, popValid[0]);
      checkValue("popData FIFO 0 held", refQ0[0], popData[0]);
      advance();
    end
    checkValue("FIFO 1 words left", 0, refQ1.size());
    drainAll();
  endtask

  task automatic randomMix();
    logic [7:0] enable;
    logic [7:0] id;
    logic [7:0] data;
    logic [7:0] ready;
    bit         pushed;
    testName = "randomMix";
    for (int c = 0; c < RandomCycles; c++) begin
      takeBits(1, enable);
      takeBits(1, id);
      takeBits(8, data);
      takeBits(2, ready);
      popReady = ready[1:0];
      if (enable[0]) begin
        tryPush(id[0], data, pushed);
      end
      advance();
    end
    drainAll();
  endtask

  initial begin
    rst             = 1'b1;
    pushCreditStall = 1'b1;
    pushValid       = 1'b0;
    pushData        = '0;
    pushFifoId      = '0;
    popReady        = '0;
    credits         = 0;
    valueErrors     = 0;
    otherErrors     = 0;
    lfsrState       = 16'd80;
    testName        = "reset";
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    creditInit();
    singleFifoOrder();
    fillShared();
    backPressure();
    randomMix();
    $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors + otherErrors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
mfifoPkg.sv
flopRam.sv
pushCreditReceiver.sv
freeList.sv
linkedListCtrl.sv
popStaging.sv
sharedMultiFifo.sv
tb_sharedMultiFifo.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_sharedMultiFifo -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/simv)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
  exit 0
fi
echo "Simulation reported a failure"
exit 1
